// File: design/bp_pkg.sv
package bp_pkg;

  // address and data path width
  localparam int XLEN = 32;

  // pc after reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // direction counter table
  localparam int BHT_SIZE  = 8;
  localparam int BHT_IDX_W = 3;

  // in-flight prediction queue
  localparam int BPQ_SIZE  = 4;
  localparam int BPQ_IDX_W = 2;
  localparam int BPQ_CNT_W = BPQ_IDX_W + 1; // holds 0..BPQ_SIZE

  // bit 0 of pc is always zero, so the tag starts at bit 1
  localparam int TAG_LSB = 1;
  localparam int TAG_W   = XLEN - TAG_LSB;

  // 2-bit saturating direction counter
  typedef enum logic [1:0] {
    CTR_SNT = 2'b00, // strongly not taken
    CTR_WNT = 2'b01, // weakly not taken
    CTR_WT  = 2'b10, // weakly taken
    CTR_ST  = 2'b11  // strongly taken
  } ctr_state_t;

  // state of a freshly allocated entry
  localparam ctr_state_t CTR_INIT = CTR_WNT;

endpackage

// File: design/bht_table.sv
`timescale 1ns/1ps

module bht_table (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   lookup_valid,
  input  logic [bp_pkg::XLEN-1:0] lookup_pc,
  output logic                   pred_taken,
  input  logic                   upd_valid,
  input  logic [bp_pkg::XLEN-1:0] upd_pc,
  input  logic                   upd_taken
);
  import bp_pkg::*;

  logic [BHT_SIZE-1:0]  valid_q;
  logic [TAG_W-1:0]     tag_q [BHT_SIZE];
  ctr_state_t           ctr_q [BHT_SIZE];
  logic [BHT_IDX_W-1:0] victim_q; // round-robin pointer

  logic [TAG_W-1:0]     look_tag;
  logic [TAG_W-1:0]     upd_tag;
  logic                 look_hit;
  logic [BHT_IDX_W-1:0] look_idx;
  logic                 upd_hit;
  logic [BHT_IDX_W-1:0] upd_idx;
  logic                 has_free;
  logic [BHT_IDX_W-1:0] free_idx;
  logic                 alloc_en;
  logic [BHT_IDX_W-1:0] alloc_idx;
  logic                 dup_tag;

  function automatic logic ctr_taken(input ctr_state_t s);
    return (s == CTR_WT) || (s == CTR_ST);
  endfunction

  // one step toward the real outcome, saturating at both ends
  function automatic ctr_state_t ctr_step(input ctr_state_t cur, input logic taken);
    ctr_state_t nxt;
    case (cur)
      CTR_SNT: nxt = taken ? CTR_WNT : CTR_SNT;
      CTR_WNT: nxt = taken ? CTR_WT  : CTR_SNT;
      CTR_WT:  nxt = taken ? CTR_ST  : CTR_WNT;
      CTR_ST:  nxt = taken ? CTR_ST  : CTR_WT;
      default: nxt = CTR_INIT;
    endcase
    return nxt;
  endfunction

  assign look_tag = lookup_pc[XLEN-1:TAG_LSB];
  assign upd_tag  = upd_pc[XLEN-1:TAG_LSB];

  // associative search on the lookup and update ports
  always_comb begin
    look_hit = 1'b0;
    look_idx = '0;
    upd_hit  = 1'b0;
    upd_idx  = '0;
    for (int i = 0; i < BHT_SIZE; i++) begin
      if (valid_q[i] && tag_q[i] == look_tag) begin
        look_hit = 1'b1;
        look_idx = BHT_IDX_W'(i);
      end
      if (valid_q[i] && tag_q[i] == upd_tag) begin
        upd_hit = 1'b1;
        upd_idx = BHT_IDX_W'(i);
      end
    end
  end

  // lowest invalid slot wins
  always_comb begin
    has_free = 1'b0;
    free_idx = '0;
    for (int i = BHT_SIZE - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        has_free = 1'b1;
        free_idx = BHT_IDX_W'(i);
      end
    end
  end

  assign alloc_en   = lookup_valid && !look_hit;
  assign alloc_idx  = has_free ? free_idx : victim_q;
  assign pred_taken = lookup_valid && look_hit && ctr_taken(ctr_q[look_idx]);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else if (alloc_en) begin
      valid_q[alloc_idx] <= 1'b1;
      if (!has_free) victim_q <= victim_q + 1'b1; // table full so the victim rotates
    end
  end

  // allocation overrides an update to the same slot
  always_ff @(posedge clk_in) begin
    if (upd_valid && upd_hit) ctr_q[upd_idx] <= ctr_step(ctr_q[upd_idx], upd_taken);
    if (alloc_en) begin
      tag_q[alloc_idx] <= look_tag;
      ctr_q[alloc_idx] <= CTR_INIT;
    end
  end

  always_comb begin
    dup_tag = 1'b0;
    for (int i = 0; i < BHT_SIZE; i++) begin
      for (int j = i + 1; j < BHT_SIZE; j++) begin
        if (valid_q[i] && valid_q[j] && tag_q[i] == tag_q[j]) dup_tag = 1'b1;
      end
    end
  end

  // allocation only on a miss keeps tags unique over time
  a_unique_tag: assert property (@(posedge clk_in) disable iff (rst_in) !dup_tag)
    else $error("bht_table: two valid entries share a tag");

endmodule

// File: design/bp_queue.sv
`timescale 1ns/1ps

module bp_queue (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    rdy_in,
  input  logic                    push_valid,
  input  logic [bp_pkg::XLEN-1:0] push_pc,
  input  logic                    push_taken,
  input  logic [bp_pkg::XLEN-1:0] push_fail_addr,
  output logic                    full,
  input  logic                    cdb_active,
  input  logic [bp_pkg::XLEN-1:0] cdb_addr,
  input  logic                    cdb_taken,
  output logic                    upd_valid,
  output logic [bp_pkg::XLEN-1:0] upd_pc,
  output logic                    upd_taken,
  output logic                    predict_fail,
  output logic [bp_pkg::XLEN-1:0] fail_addr
);
  import bp_pkg::*;

  // entry payload
  logic [XLEN-1:0] pc_q    [BPQ_SIZE];
  logic            taken_q [BPQ_SIZE]; // predicted direction
  logic [XLEN-1:0] fail_q  [BPQ_SIZE]; // recovery address

  logic [BPQ_IDX_W-1:0] front_q;
  logic [BPQ_IDX_W-1:0] rear_q;
  logic [BPQ_CNT_W-1:0] count_q;

  logic empty;
  logic pop;

  assign empty = (count_q == '0);
  assign full  = (count_q == BPQ_CNT_W'(BPQ_SIZE));

  // only the oldest branch can resolve; other bus results pass by
  assign pop = rdy_in && cdb_active && !empty && (pc_q[front_q] == cdb_addr);

  assign upd_valid    = pop;
  assign upd_pc       = pc_q[front_q];
  assign upd_taken    = cdb_taken;
  assign predict_fail = pop && (taken_q[front_q] != cdb_taken);
  assign fail_addr    = predict_fail ? fail_q[front_q] : '0;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      front_q <= '0;
      rear_q  <= '0;
      count_q <= '0;
    end else if (rdy_in) begin
      if (predict_fail) begin
        // younger entries are wrong-path so all of them are dropped
        front_q <= '0;
        rear_q  <= '0;
        count_q <= '0;
      end else begin
        if (push_valid) rear_q <= rear_q + 1'b1;
        if (pop) front_q <= front_q + 1'b1;
        case ({push_valid, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q; // both or neither
        endcase
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && push_valid) begin
      pc_q[rear_q]    <= push_pc;
      taken_q[rear_q] <= push_taken;
      fail_q[rear_q]  <= push_fail_addr;
    end
  end

  // fetch side must stall instead of pushing into a full queue
  a_no_push_full: assert property (@(posedge clk_in) disable iff (rst_in)
    push_valid |-> !full)
    else $error("bp_queue: push while full");

  // a branch seen during a redirect is wrong-path
  a_no_push_fail: assert property (@(posedge clk_in) disable iff (rst_in)
    push_valid |-> !predict_fail)
    else $error("bp_queue: push in a failing cycle");

endmodule

// File: design/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    rdy_in,
  input  logic                    branch,
  input  logic [bp_pkg::XLEN-1:0] imm,
  input  logic                    inst_length,
  input  logic                    pred_taken,
  input  logic                    queue_full,
  input  logic                    predict_fail,
  input  logic [bp_pkg::XLEN-1:0] fail_addr,
  output logic [bp_pkg::XLEN-1:0] pc,
  output logic                    lookup_valid,
  output logic                    push_valid,
  output logic                    push_taken,
  output logic [bp_pkg::XLEN-1:0] push_fail_addr,
  output logic                    need_branch,
  output logic [bp_pkg::XLEN-1:0] branch_addr,
  output logic                    fetch_stall
);
  import bp_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] seq_addr;
  logic [XLEN-1:0] taken_addr;
  logic [XLEN-1:0] next_pc;
  logic            accept; // branch accepted into the queue this cycle

  assign pc = pc_q;

  // inst_length high means a full 32-bit instruction
  assign seq_addr   = pc_q + (inst_length ? XLEN'(4) : XLEN'(2));
  assign taken_addr = pc_q + imm;

  assign accept = rdy_in && branch && !queue_full && !predict_fail;

  assign lookup_valid   = accept;
  assign push_valid     = accept;
  assign push_taken     = pred_taken;
  assign need_branch    = accept && pred_taken;
  assign branch_addr    = pred_taken ? taken_addr : seq_addr;
  assign push_fail_addr = pred_taken ? seq_addr : taken_addr; // the path not followed

  // hold the branch while the queue has no room
  assign fetch_stall = rdy_in && branch && queue_full && !predict_fail;

  always_comb begin
    if (predict_fail) begin
      next_pc = fail_addr; // redirect beats everything
    end else if (!rdy_in || fetch_stall) begin
      next_pc = pc_q;
    end else if (need_branch) begin
      next_pc = branch_addr;
    end else begin
      next_pc = seq_addr;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= next_pc;
    end
  end

endmodule

// File: design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    rdy_in,
  input  logic                    branch,
  input  logic [bp_pkg::XLEN-1:0] imm,
  input  logic                    inst_length,
  input  logic                    cdb_active,
  input  logic [bp_pkg::XLEN-1:0] cdb_addr,
  input  logic                    cdb_taken,
  output logic [bp_pkg::XLEN-1:0] pc,
  output logic                    need_branch,
  output logic [bp_pkg::XLEN-1:0] branch_addr,
  output logic                    predict_fail,
  output logic [bp_pkg::XLEN-1:0] fail_addr,
  output logic                    fetch_stall
);
  import bp_pkg::*;

  // fetch to table
  logic            lookup_valid;
  logic            pred_taken;

  // fetch to queue
  logic            push_valid;
  logic            push_taken;
  logic [XLEN-1:0] push_fail_addr;
  logic            queue_full;

  // queue to table for counter training
  logic            upd_valid;
  logic [XLEN-1:0] upd_pc;
  logic            upd_taken;

  fetch_pc u_fetch_pc (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .branch         (branch),
    .imm            (imm),
    .inst_length    (inst_length),
    .pred_taken     (pred_taken),
    .queue_full     (queue_full),
    .predict_fail   (predict_fail),
    .fail_addr      (fail_addr),
    .pc             (pc),
    .lookup_valid   (lookup_valid),
    .push_valid     (push_valid),
    .push_taken     (push_taken),
    .push_fail_addr (push_fail_addr),
    .need_branch    (need_branch),
    .branch_addr    (branch_addr),
    .fetch_stall    (fetch_stall)
  );

  bht_table u_bht_table (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .lookup_valid (lookup_valid),
    .lookup_pc    (pc),       // lookup is for the current fetch pc
    .pred_taken   (pred_taken),
    .upd_valid    (upd_valid),
    .upd_pc       (upd_pc),
    .upd_taken    (upd_taken)
  );

  bp_queue u_bp_queue (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .push_valid     (push_valid),
    .push_pc        (pc),
    .push_taken     (push_taken),
    .push_fail_addr (push_fail_addr),
    .full           (queue_full),
    .cdb_active     (cdb_active),
    .cdb_addr       (cdb_addr),
    .cdb_taken      (cdb_taken),
    .upd_valid      (upd_valid),
    .upd_pc         (upd_pc),
    .upd_taken      (upd_taken),
    .predict_fail   (predict_fail),
    .fail_addr      (fail_addr)
  );

endmodule

// File: verif/tb_branch_unit.sv
`timescale 1ns/1ps

module tb_branch_unit;
  import bp_pkg::*;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_LINES    = 400; // bound on golden lines read
  localparam int MAX_FILL     = 4;   // up to 3 filler cycles per filler point

  logic            clk_in;
  logic            rst_in;
  logic            rdy_in;
  logic            branch;
  logic [XLEN-1:0] imm;
  logic            inst_length;
  logic            cdb_active;
  logic [XLEN-1:0] cdb_addr;
  logic            cdb_taken;
  logic [XLEN-1:0] pc;
  logic            need_branch;
  logic [XLEN-1:0] branch_addr;
  logic            predict_fail;
  logic [XLEN-1:0] fail_addr;
  logic            fetch_stall;

  int              seed;
  logic [XLEN-1:0] addr_off; // shift of all later addresses caused by filler cycles

  branch_unit u_dut (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .branch       (branch),
    .imm          (imm),
    .inst_length  (inst_length),
    .cdb_active   (cdb_active),
    .cdb_addr     (cdb_addr),
    .cdb_taken    (cdb_taken),
    .pc           (pc),
    .need_branch  (need_branch),
    .branch_addr  (branch_addr),
    .predict_fail (predict_fail),
    .fail_addr    (fail_addr),
    .fetch_stall  (fetch_stall)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [XLEN-1:0] got,
                           input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("ERR %0t: %s is %h, expected %h", $time, name, got, exp);
      report_fail("output mismatch against golden data");
    end
  endtask

  // drive one cycle at the edge, compare just before the next one
  task automatic run_cycle(input logic r, input logic b, input logic [XLEN-1:0] im,
                           input logic l, input logic ca, input logic [XLEN-1:0] caddr,
                           input logic ct, input logic [XLEN-1:0] e_pc,
                           input logic [XLEN-1:0] e_nb, input logic [XLEN-1:0] e_ba,
                           input logic [XLEN-1:0] e_pf, input logic [XLEN-1:0] e_fa,
                           input logic [XLEN-1:0] e_st);
    @(posedge clk_in);
    rdy_in      <= r;
    branch      <= b;
    imm         <= im;
    inst_length <= l;
    cdb_active  <= ca;
    cdb_addr    <= caddr;
    cdb_taken   <= ct;
    #(CLK_PERIOD - 1);
    check_val("pc", pc, e_pc);
    check_val("need_branch", XLEN'(need_branch), e_nb);
    check_val("branch_addr", branch_addr, e_ba);
    check_val("predict_fail", XLEN'(predict_fail), e_pf);
    check_val("fail_addr", fail_addr, e_fa);
    check_val("fetch_stall", XLEN'(fetch_stall), e_st);
  endtask

  // plain sequential cycles where pc steps by 4 or 2
  task automatic run_filler(input logic [XLEN-1:0] start_pc);
    int              n;
    logic            len;
    logic [XLEN-1:0] fpc;
    logic [XLEN-1:0] step;
    n   = int'($unsigned($random(seed)) % 32'(MAX_FILL));
    fpc = start_pc + addr_off;
    for (int i = 0; i < n; i++) begin
      len  = 1'($random(seed));
      step = len ? XLEN'(4) : XLEN'(2);
      run_cycle(1'b1, 1'b0, XLEN'($random(seed)), len, 1'b0, XLEN'($random(seed)), 1'b0,
                fpc, '0, fpc + step, '0, '0, '0);
      fpc      = fpc + step;
      addr_off = addr_off + step;
    end
  endtask

  initial begin
    int              fd;
    int              code;
    int              nlines;
    string           line;
    logic [XLEN-1:0] f_rdy, f_br, f_imm, f_len, f_ca, f_caddr, f_ct;
    logic [XLEN-1:0] f_pc, f_nb, f_ba, f_pf, f_fa, f_st;
    rst_in      = 1'b1;
    rdy_in      = 1'b0;
    branch      = 1'b0;
    imm         = '0;
    inst_length = 1'b0;
    cdb_active  = 1'b0;
    cdb_addr    = '0;
    cdb_taken   = 1'b0;
    seed        = 32'h70cf_1024;
    addr_off    = '0;
    repeat (RESET_CYCLES) @(posedge clk_in);
    rst_in <= 1'b0;

    fd = $fopen("verif/branch_golden.txt", "r");
    if (fd == 0) report_fail("could not open verif/branch_golden.txt");
    nlines = 0;
    while (!$feof(fd)) begin
      nlines++;
      if (nlines > MAX_LINES) report_fail("timeout: golden file did not end within line limit");
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        if (line.getc(0) == "F") begin
          code = $sscanf(line, "F %h", f_pc);
          if (code != 1) report_fail("golden filler line has no pc");
          run_filler(f_pc);
        end else begin
          code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                         f_rdy, f_br, f_imm, f_len, f_ca, f_caddr, f_ct,
                         f_pc, f_nb, f_ba, f_pf, f_fa, f_st);
          if (code != 13) report_fail("golden line does not hold 13 fields");
          run_cycle(f_rdy[0], f_br[0], f_imm, f_len[0], f_ca[0],
                    f_ca[0] ? f_caddr + addr_off : f_caddr, f_ct[0],
                    f_pc + addr_off, f_nb, f_ba + addr_off, f_pf,
                    f_pf[0] ? f_fa + addr_off : f_fa, f_st);
        end
      end
    end
    $fclose(fd);

    $display("All tests passed!");
    $finish;
  end

endmodule

// File: verif/branch_golden.txt
# rdy branch imm len cdb_active cdb_addr cdb_taken | pc need_branch branch_addr predict_fail fail_addr fetch_stall
# all hex, len 1 = 4 bytes; F <pc> marks a point for random filler cycles
1 0 00000000 1 0 00000000 0 00000000 0 00000004 0 00000000 0
1 0 00000000 0 0 00000000 0 00000004 0 00000006 0 00000000 0
1 0 00000000 0 0 00000000 0 00000006 0 00000008 0 00000000 0
1 0 00000000 1 0 00000000 0 00000008 0 0000000c 0 00000000 0
F 0000000c
# cold branch, mispredict, training and saturation
1 1 fffffff8 1 0 00000000 0 0000000c 0 00000010 0 00000000 0
1 0 00000000 1 1 0000000c 1 00000010 0 00000014 1 00000004 0
1 0 00000000 1 0 00000000 0 00000004 0 00000008 0 00000000 0
1 0 00000000 1 0 00000000 0 00000008 0 0000000c 0 00000000 0
1 1 fffffff8 1 0 00000000 0 0000000c 1 00000004 0 00000000 0
1 0 00000000 1 1 0000000c 1 00000004 0 00000008 0 00000000 0
1 0 00000000 1 0 00000000 0 00000008 0 0000000c 0 00000000 0
1 1 fffffff8 1 0 00000000 0 0000000c 1 00000004 0 00000000 0
1 0 00000000 1 1 0000000c 1 00000004 0 00000008 0 00000000 0
1 0 00000000 1 0 00000000 0 00000008 0 0000000c 0 00000000 0
1 1 fffffff8 1 0 00000000 0 0000000c 1 00000004 0 00000000 0
1 0 00000000 1 1 0000000c 0 00000004 0 00000008 1 00000010 0
1 1 fffffffc 1 0 00000000 0 00000010 0 00000014 0 00000000 0
1 0 00000000 1 1 00000010 1 00000014 0 00000018 1 0000000c 0
1 1 fffffff8 1 0 00000000 0 0000000c 1 00000004 0 00000000 0
1 0 00000000 1 1 0000000c 0 00000004 0 00000008 1 00000010 0
1 0 00000000 1 0 00000000 0 00000010 0 00000014 0 00000000 0
F 00000014
# recovery with a younger branch flushed
1 1 00000100 1 0 00000000 0 00000014 0 00000018 0 00000000 0
1 1 00000020 0 0 00000000 0 00000018 0 0000001a 0 00000000 0
1 0 00000000 1 1 00000018 0 0000001a 0 0000001e 0 00000000 0
1 1 00000040 1 1 00000014 1 0000001e 0 00000022 1 00000114 0
1 0 00000000 1 1 00000018 1 00000114 0 00000118 0 00000000 0
F 00000118
# queue back-pressure
1 1 00000080 1 0 00000000 0 00000118 0 0000011c 0 00000000 0
1 1 00000080 1 0 00000000 0 0000011c 0 00000120 0 00000000 0
1 1 00000080 1 0 00000000 0 00000120 0 00000124 0 00000000 0
1 1 00000080 1 0 00000000 0 00000124 0 00000128 0 00000000 0
1 1 00000080 1 0 00000000 0 00000128 0 0000012c 0 00000000 1
1 1 00000080 1 1 00000118 0 00000128 0 0000012c 0 00000000 1
1 1 00000080 1 0 00000000 0 00000128 0 0000012c 0 00000000 0
1 0 00000000 1 1 0000011c 0 0000012c 0 00000130 0 00000000 0
1 0 00000000 1 1 00000120 0 00000130 0 00000134 0 00000000 0
1 0 00000000 1 1 00000124 0 00000134 0 00000138 0 00000000 0
1 0 00000000 1 1 00000128 0 00000138 0 0000013c 0 00000000 0
F 0000013c
# global pause
0 1 00000080 1 1 0000013c 1 0000013c 0 00000140 0 00000000 0
0 0 00000000 0 0 00000000 0 0000013c 0 0000013e 0 00000000 0
1 0 00000000 1 0 00000000 0 0000013c 0 00000140 0 00000000 0
1 0 00000000 0 0 00000000 0 00000140 0 00000142 0 00000000 0
1 0 00000000 1 0 00000000 0 00000142 0 00000146 0 00000000 0

// File: tb.f
design/bp_pkg.sv
design/bht_table.sv
design/bp_queue.sv
design/fetch_pc.sv
design/branch_unit.sv
verif/tb_branch_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f tb.f --top-module tb_branch_unit \
  -Mdir "$OBJ" -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
  echo "simulation FAILED"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

echo "simulation passed"
exit 0
